/* alu.sv */
`timescale 1ns/1ps

module alu #(
	parameter int dataWidth = cpuPkg::dataWidth
) (
	input logic clk,
	input logic reset,
	input cpuPkg::opcodeT op,
	input logic [dataWidth-1:0] imm, // already sign-extended
	input logic aluEn,               // write cycle pulse
	regPortIf.exec regs,
	output logic [dataWidth-1:0] result,
	output cpuPkg::psrT psr
);

	localparam int msb = dataWidth - 1;

	logic [dataWidth-1:0] dstVal;
	logic [dataWidth-1:0] srcVal;
	logic [dataWidth-1:0] addend;
	logic [dataWidth:0] sum;  // extra bit is the carry
	logic [dataWidth:0] diff; // extra bit is the borrow
	logic addOvf;
	logic subOvf;
	logic [dataWidth-1:0] shiftMag;
	logic [dataWidth-1:0] value;
	cpuPkg::psrT nextPsr;

	assign dstVal = regs.readData1;
	assign srcVal = regs.readData2;

	// ADDI adds the immediate instead of the source register
	assign addend = (op == cpuPkg::ADDI) ? imm : srcVal;
	assign sum = {1'b0, dstVal} + {1'b0, addend};
	assign diff = {1'b0, dstVal} - {1'b0, srcVal};

	// same signs in, different sign out
	assign addOvf = (dstVal[msb] == addend[msb]) && (sum[msb] != dstVal[msb]);
	// signs differ and the result left the destination sign
	assign subOvf = (dstVal[msb] != srcVal[msb]) && (diff[msb] != dstVal[msb]);

	// magnitude of a negative shift amount
	assign shiftMag = srcVal[msb] ? (~srcVal + 1'b1) : srcVal;

	always_comb begin
		case (op)
			cpuPkg::ADD,
			cpuPkg::ADDI: value = sum[msb:0];
			cpuPkg::SUB,
			cpuPkg::CMP:  value = diff[msb:0]; // CMP only shows it on result
			cpuPkg::AND:  value = dstVal & srcVal;
			cpuPkg::OR:   value = dstVal | srcVal;
			cpuPkg::XOR:  value = dstVal ^ srcVal;
			cpuPkg::MOV,
			cpuPkg::SWAP: value = srcVal;
			// amounts at or past the width shift everything out
			cpuPkg::LSH:  value = srcVal[msb] ? (dstVal >> shiftMag) : (dstVal << shiftMag);
			cpuPkg::MOVI: value = imm;
			default:      value = dstVal; // NOP, nothing is written
		endcase
	end

	assign regs.writeData1 = value;  // back to the destination
	assign regs.writeData2 = dstVal; // old destination into the source, SWAP only

	// flag update, subset depends on the operation
	always_comb begin
		nextPsr = psr;
		case (op)
			cpuPkg::ADD,
			cpuPkg::ADDI: begin
				nextPsr.carry = sum[dataWidth];
				nextPsr.overflow = addOvf;
				nextPsr.negative = value[msb];
				nextPsr.zero = (value == '0);
			end
			cpuPkg::SUB,
			cpuPkg::CMP: begin
				nextPsr.carry = diff[dataWidth]; // set on borrow
				nextPsr.overflow = subOvf;
				nextPsr.negative = value[msb];
				nextPsr.zero = (value == '0);
			end
			cpuPkg::AND,
			cpuPkg::OR,
			cpuPkg::XOR,
			cpuPkg::LSH: begin
				nextPsr.negative = value[msb];
				nextPsr.zero = (value == '0);
			end
			default: nextPsr = psr; // moves, SWAP and NOP keep flags
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset)
			psr <= '0;
		else if (aluEn)
			psr <= nextPsr;
	end

	// result held until the next write cycle
	always_ff @(posedge clk) begin
		if (aluEn)
			result <= value;
	end

endmodule

/* cpuPkg.sv */
package cpuPkg;

	// default widths, overridden from execCore
	localparam int dataWidth = 16;
	localparam int regBits = 4; // 16 registers

	localparam int instrWidth = 16;

	// instruction fields
	localparam int opMsb = 15;
	localparam int opLsb = 12;
	localparam int opWidth = opMsb - opLsb + 1;
	localparam int dstLsb = 8; // destination reg, bits 11..8
	localparam int srcLsb = 4; // source reg, bits 7..4
	localparam int immMsb = 7; // immediate overlaps the source field
	localparam int immLsb = 0;
	localparam int immWidth = immMsb - immLsb + 1;

	// opcodes, codes past CMP decode as NOP
	typedef enum logic [opWidth-1:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		MOV  = 4'h5,
		SWAP = 4'h6, // only user of write port 2
		LSH  = 4'h7, // signed shift amount
		ADDI = 4'h8,
		MOVI = 4'h9,
		CMP  = 4'hA, // flags only
		NOP  = 4'hF
	} opcodeT;

	// processor status register
	typedef struct packed {
		logic carry;    // unsigned carry, or borrow on subtract
		logic overflow; // signed overflow
		logic negative;
		logic zero;
	} psrT;

endpackage

/* execCore.sv */
`timescale 1ns/1ps

module execCore #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int regBits = cpuPkg::regBits
) (
	input logic clk,
	input logic reset, // active low, synchronous
	input logic [cpuPkg::instrWidth-1:0] instr,
	input logic instrValid, // one-cycle strobe
	output logic busy,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output cpuPkg::psrT psr
);

	cpuPkg::opcodeT op;
	logic [dataWidth-1:0] imm;
	logic aluEn;

	// shared register file port bundle
	regPortIf #(
		.dataWidth(dataWidth),
		.regBits(regBits)
	) regs ();

	// accepts the instruction, sequences read then write
	instrDecoder #(
		.dataWidth(dataWidth),
		.regBits(regBits)
	) instrDecoder_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.busy(busy),
		.resultValid(resultValid),
		.op(op),
		.imm(imm),
		.aluEn(aluEn),
		.regs(regs.decode)
	);

	registerFile #(
		.dataWidth(dataWidth),
		.regBits(regBits)
	) registerFile_inst (
		.clk(clk),
		.reset(reset),
		.regs(regs.store)
	);

	// result and psr are registered inside
	alu #(
		.dataWidth(dataWidth)
	) alu_inst (
		.clk(clk),
		.reset(reset),
		.op(op),
		.imm(imm),
		.aluEn(aluEn),
		.regs(regs.exec),
		.result(result),
		.psr(psr)
	);

endmodule

/* execCoreModel.svh */
`ifndef execCoreModelSvh
`define execCoreModelSvh

// reference state, advanced as each result retires
logic [15:0] modelRegs [16];
cpuPkg::psrT modelPsr;

function automatic logic [15:0] signExtend(input logic [7:0] value);
	return {{8{value[7]}}, value};
endfunction

// positive amount shifts left, negative shifts right
function automatic logic [15:0] shiftBy(input logic [15:0] value, input logic [15:0] amount);
	int signedAmount;
	signedAmount = int'($signed(amount));
	if (signedAmount >= 16 || signedAmount <= -16)
		return 16'h0; // all bits gone
	else if (signedAmount >= 0)
		return value << signedAmount;
	else
		return value >> (-signedAmount); // logical
endfunction

// value an instruction produces from the current model registers
function automatic logic [15:0] modelValue(input logic [15:0] word);
	cpuPkg::opcodeT code;
	logic [15:0] dst;
	logic [15:0] src;
	code = cpuPkg::opcodeT'(word[15:12]);
	dst = modelRegs[word[11:8]];
	src = modelRegs[word[7:4]];
	case (code)
		cpuPkg::ADD: return dst + src;
		cpuPkg::SUB, cpuPkg::CMP: return dst - src;
		cpuPkg::AND: return dst & src;
		cpuPkg::OR: return dst | src;
		cpuPkg::XOR: return dst ^ src;
		cpuPkg::MOV, cpuPkg::SWAP: return src;
		cpuPkg::LSH: return shiftBy(dst, src);
		cpuPkg::ADDI: return dst + signExtend(word[7:0]);
		cpuPkg::MOVI: return signExtend(word[7:0]);
		default: return dst;
	endcase
endfunction

function automatic cpuPkg::psrT modelFlags(input logic [15:0] word);
	cpuPkg::psrT flags;
	cpuPkg::opcodeT code;
	logic [15:0] dst;
	logic [15:0] other;
	logic [15:0] value;
	int exact; // signed result before it wraps
	flags = modelPsr; // moves keep everything
	code = cpuPkg::opcodeT'(word[15:12]);
	dst = modelRegs[word[11:8]];
	other = (code == cpuPkg::ADDI) ? signExtend(word[7:0]) : modelRegs[word[7:4]];
	value = modelValue(word);
	if (code == cpuPkg::ADD || code == cpuPkg::ADDI) begin
		flags.carry = (int'(dst) + int'(other)) > 65535;
		exact = int'($signed(dst)) + int'($signed(other));
		flags.overflow = (exact > 32767) || (exact < -32768);
	end else if (code == cpuPkg::SUB || code == cpuPkg::CMP) begin
		flags.carry = dst < other; // borrow
		exact = int'($signed(dst)) - int'($signed(other));
		flags.overflow = (exact > 32767) || (exact < -32768);
	end
	if (code inside {cpuPkg::ADD, cpuPkg::ADDI, cpuPkg::SUB, cpuPkg::CMP,
			cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR, cpuPkg::LSH}) begin
		flags.negative = value[15];
		flags.zero = (value == 16'h0);
	end
	return flags;
endfunction

task automatic retire(input logic [15:0] word);
	cpuPkg::opcodeT code;
	logic [15:0] value;
	logic [15:0] oldDst;
	code = cpuPkg::opcodeT'(word[15:12]);
	value = modelValue(word);
	oldDst = modelRegs[word[11:8]];
	modelPsr = modelFlags(word); // before the registers move
	if (code != cpuPkg::CMP && code != cpuPkg::NOP)
		modelRegs[word[11:8]] = value;
	if (code == cpuPkg::SWAP)
		modelRegs[word[7:4]] = oldDst; // port 2 wins on a self swap
endtask

task automatic clearModel();
	for (int i = 0; i < 16; i++)
		modelRegs[i] = 16'h0;
	modelPsr = '0;
endtask

`endif

/* execCoreTb.sv */
`timescale 1ns/1ps

module execCoreTb;

	logic clk;
	logic reset;
	logic [15:0] instr;
	logic instrValid;
	logic busy;
	logic resultValid;
	logic [15:0] result;
	cpuPkg::psrT psr;

	logic accepted;
	logic [15:0] pending [$]; // accepted, not yet retired
	logic [15:0] expResult;
	cpuPkg::psrT expPsr;
	cpuPkg::opcodeT mixOps [7] = '{cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR,
		cpuPkg::XOR, cpuPkg::LSH, cpuPkg::CMP};

	`include "execCoreModel.svh"

	execCore #(
		.dataWidth(16),
		.regBits(4)
	) execCore_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.busy(busy),
		.resultValid(resultValid),
		.result(result),
		.psr(psr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign accepted = reset && instrValid && !busy;

	// model trails the DUT by one entry per accepted instruction
	always @(posedge clk) begin
		if (!reset) begin
			pending.delete();
			clearModel();
		end else begin
			if (resultValid && pending.size() > 0)
				retire(pending.pop_front());
			if (accepted)
				pending.push_back(instr);
		end
	end

	// expectation for the oldest entry, settled before the next rising edge
	always @(negedge clk) begin
		if (pending.size() > 0) begin
			expResult = modelValue(pending[0]);
			expPsr = modelFlags(pending[0]);
		end
	end

	task automatic reportMismatch(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("Mismatch %s expected %h actual %h", name, expected, actual);
		$display("Testbench failed");
		$fatal(1, "%s check", name);
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	resultCheck: assert property (@(posedge clk) disable iff (!reset)
		resultValid |-> result == expResult)
		else reportMismatch("result", $sampled(expResult), $sampled(result));

	psrCheck: assert property (@(posedge clk) disable iff (!reset)
		resultValid |-> psr == expPsr)
		else reportMismatch("psr", {12'h0, $sampled(expPsr)}, {12'h0, $sampled(psr)});

	// acceptance edge, then three edges to the sampled pulse
	latencyCheck: assert property (@(posedge clk) disable iff (!reset)
		resultValid == $past(accepted, 3))
		else reportMismatch("resultValid", {15'h0, !$sampled(resultValid)},
			{15'h0, $sampled(resultValid)});

	resetCheck: assert property (@(posedge clk) !reset |=> !busy && !resultValid && psr == '0)
		else reportFailure("busy, resultValid or psr still set the cycle after reset");

	function automatic logic [15:0] encodeRegs(input cpuPkg::opcodeT code, input int dst,
			input int src);
		return {code, 4'(dst), 4'(src), 4'h0};
	endfunction

	function automatic logic [15:0] encodeImm(input cpuPkg::opcodeT code, input int dst,
			input logic [7:0] value);
		return {code, 4'(dst), value};
	endfunction

	// strobe one instruction as soon as busy is low
	task automatic issue(input logic [15:0] word);
		int cycles;
		cycles = 0;
		while (busy) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
				reportFailure("busy did not fall within 20 cycles");
		end
		instr = word;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic strobeWhileBusy(input logic [15:0] word);
		if (!busy)
			reportFailure("busy was low where a blocked strobe was intended");
		instr = word;
		instrValid = 1'b1; // must be dropped
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (busy || pending.size() > 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
				reportFailure("resultValid did not arrive within 20 cycles");
		end
	endtask

	task automatic readAll();
		for (int r = 0; r < 16; r++)
			issue(encodeRegs(cpuPkg::MOV, r, r)); // rewrites the same value
	endtask

	initial begin
		logic [7:0] value;
		int dst;
		int src;
		void'($urandom(32'h40bf_26fc));
		reset = 1'b0;
		instr = 16'h0;
		instrValid = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b1;
		for (int r = 0; r < 16; r++)
			issue(encodeRegs(cpuPkg::MOV, r, 15 - r)); // all zero after reset
		// immediates of both signs, ADDI straight behind its MOVI
		for (int i = 0; i < 16; i++) begin
			value = 8'($urandom);
			value[7] = i[0];
			issue(encodeImm(cpuPkg::MOVI, i, value));
			value = 8'($urandom);
			value[7] = i[1];
			issue(encodeImm(cpuPkg::ADDI, i, value));
		end
		for (int i = 0; i < 60; i++) begin
			dst = $urandom_range(15, 0);
			src = $urandom_range(15, 0);
			if (i % 5 == 0) begin
				// small shift amounts, both directions
				issue(encodeImm(cpuPkg::MOVI, src, 8'($urandom_range(40, 0) - 20)));
				issue(encodeRegs(cpuPkg::LSH, dst, src));
			end else
				issue(encodeRegs(mixOps[$urandom_range(6, 0)], dst, src));
		end
		readAll(); // CMP left no trace
		issue(encodeImm(cpuPkg::MOVI, 3, 8'h5a));
		issue(encodeImm(cpuPkg::MOVI, 9, 8'ha5));
		issue(encodeRegs(cpuPkg::SWAP, 3, 9));
		issue(encodeRegs(cpuPkg::MOV, 3, 3));
		issue(encodeRegs(cpuPkg::MOV, 9, 9));
		issue(encodeRegs(cpuPkg::SWAP, 6, 6));
		issue(encodeRegs(cpuPkg::MOV, 6, 6));
		issue(encodeImm(cpuPkg::MOVI, 1, 8'h80));
		issue(encodeImm(cpuPkg::MOVI, 0, 8'h08));
		issue(encodeRegs(cpuPkg::LSH, 1, 0)); // 8000, most negative
		issue(encodeImm(cpuPkg::ADDI, 1, 8'hff)); // wraps to 7fff, carry and overflow
		issue(encodeImm(cpuPkg::ADDI, 1, 8'h01)); // back to 8000, positive overflow
		issue(encodeRegs(cpuPkg::ADD, 2, 1));
		issue(encodeImm(cpuPkg::MOVI, 7, 8'h05));
		issue(encodeImm(cpuPkg::ADDI, 7, 8'hfb)); // zero with carry
		issue(encodeImm(cpuPkg::MOVI, 5, 8'h11));
		strobeWhileBusy(encodeImm(cpuPkg::MOVI, 5, 8'h77));
		waitDrained();
		issue(encodeRegs(cpuPkg::MOV, 5, 5)); // still 0011
		waitDrained();
		issue(encodeRegs(cpuPkg::SUB, 4, 7));
		reset = 1'b0; // hits the read cycle
		repeat (3) @(negedge clk);
		reset = 1'b1;
		readAll();
		waitDrained();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
cpuPkg.sv
regPortIf.sv
registerFile.sv
alu.sv
instrDecoder.sv
execCore.sv
execCoreTb.sv

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int regBits = cpuPkg::regBits
) (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::instrWidth-1:0] instr,
	input logic instrValid,
	output logic busy,
	output logic resultValid,
	output cpuPkg::opcodeT op,
	output logic [dataWidth-1:0] imm,
	output logic aluEn,
	regPortIf.decode regs
);

	// idle, then read cycle, then write cycle
	typedef enum logic [1:0] {
		stateIdle,
		stateRead,
		stateWrite
	} stateT;

	stateT state;
	stateT nextState;
	logic accept;
	logic writeCycle;
	logic writesDst;
	logic [cpuPkg::opWidth-1:0] rawOp;
	cpuPkg::opcodeT decodedOp;
	logic [regBits-1:0] dstLatch;
	logic [regBits-1:0] srcLatch;
	logic [cpuPkg::immWidth-1:0] immLatch;

	// busy only while the read is in flight
	// a new instruction may enter during the write cycle,
	// its read lands one edge after the write
	assign busy = (state == stateRead);
	assign accept = instrValid && !busy;
	assign writeCycle = (state == stateWrite);

	assign rawOp = instr[cpuPkg::opMsb:cpuPkg::opLsb];

	// unused codes fold into NOP
	always_comb begin
		if (rawOp <= cpuPkg::CMP)
			decodedOp = cpuPkg::opcodeT'(rawOp);
		else
			decodedOp = cpuPkg::NOP;
	end

	always_comb begin
		if (accept)
			nextState = stateRead;
		else if (state == stateRead)
			nextState = stateWrite;
		else
			nextState = stateIdle; // write cycle with nothing waiting
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= stateIdle;
			op <= cpuPkg::NOP;
			resultValid <= 1'b0;
		end else begin
			state <= nextState;
			if (accept)
				op <= decodedOp;
			resultValid <= writeCycle; // cycle after the write edge
		end
	end

	// fields held for the whole instruction
	always_ff @(posedge clk) begin
		if (accept) begin
			dstLatch <= instr[cpuPkg::dstLsb +: regBits];
			srcLatch <= instr[cpuPkg::srcLsb +: regBits];
			immLatch <= instr[cpuPkg::immMsb:cpuPkg::immLsb];
		end
	end

	assign regs.dstAddr = dstLatch;
	assign regs.srcAddr = srcLatch;

	// sign-extend the 8-bit immediate
	assign imm = {{(dataWidth - cpuPkg::immWidth){immLatch[cpuPkg::immWidth-1]}}, immLatch};

	// CMP and NOP leave the file alone
	assign writesDst = (op != cpuPkg::CMP) && (op != cpuPkg::NOP);

	assign regs.writeEn1 = writeCycle && writesDst;
	assign regs.writeEn2 = writeCycle && (op == cpuPkg::SWAP);
	assign aluEn = writeCycle; // flags and result latch with the write

endmodule

/* regPortIf.sv */
`timescale 1ns/1ps

// register file ports, addresses shared between read and write
interface regPortIf #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int regBits = cpuPkg::regBits
);
	logic [regBits-1:0] srcAddr; // read port 2, write port 2
	logic [regBits-1:0] dstAddr; // read port 1, write port 1
	logic writeEn1;
	logic writeEn2;
	logic [dataWidth-1:0] writeData1;
	logic [dataWidth-1:0] writeData2;
	logic [dataWidth-1:0] readData1; // destination value
	logic [dataWidth-1:0] readData2; // source value

	// sequencer side
	modport decode (output srcAddr, dstAddr, writeEn1, writeEn2);

	// operation unit side
	modport exec (input readData1, readData2, output writeData1, writeData2);

	// storage side
	modport store (
		input srcAddr, dstAddr, writeEn1, writeEn2, writeData1, writeData2,
		output readData1, readData2
	);

endinterface

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int regBits = cpuPkg::regBits
) (
	input logic clk,
	input logic reset,
	regPortIf.store regs
);

	localparam int numRegs = 1 << regBits;

	logic [dataWidth-1:0] regArray [numRegs]; // the register file itself

	// writes, port 2 last so it wins on a shared address
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < numRegs; i++) begin // every entry, not dataWidth
				regArray[i] <= '0;
			end
		end else begin
			if (regs.writeEn1)
				regArray[regs.dstAddr] <= regs.writeData1;
			if (regs.writeEn2)
				regArray[regs.srcAddr] <= regs.writeData2;
		end
	end

	// registered reads every cycle
	// same-edge write is not visible, old value comes out
	always_ff @(posedge clk) begin
		regs.readData1 <= regArray[regs.dstAddr];
		regs.readData2 <= regArray[regs.srcAddr];
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the execCore testbench with Verilator and runs it
# a failing check ends in $fatal, so the model exits nonzero
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module execCoreTb \
	-f files.f -o execCoreSim

./obj_dir/execCoreSim
